/* tb.f */
+incdir+include
hw/cim_pkg.sv
hw/cim_bus_decode.sv
hw/cim_sequencer.sv
hw/cim_row_alu.sv
hw/cim_row_array.sv
hw/cim_read_return.sv
hw/cim_top.sv
dv/cim_tb.sv

/* Bender.yml */
package:
  name: cim_row_ctrl

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/cim_pkg.sv
      - hw/cim_bus_decode.sv
      - hw/cim_sequencer.sv
      - hw/cim_row_alu.sv
      - hw/cim_row_array.sv
      - hw/cim_read_return.sv
      - hw/cim_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/cim_tb.sv

/* dv/cim_tb.sv */
/*
 * testbench for the compute-in-memory row controller
 * builds a table of Avalon-MM accesses from a row model, applies it in a loop
 * and checks read data and the waitrequest / readdatavalid timing
 */
`timescale 1ns/100ps
`include "cim_settings.svh"

module cim_tb
    import cim_pkg::*;
();

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 10;
    // watchdog budget per table entry
    localparam int CYCLES_PER_STEP = 10;
    localparam int WATCHDOG_MARGIN = 50;
    // rows the tests work on are all loaded first
    localparam int POOL_ROWS    = 16;
    localparam int RANDOM_STEPS = 40;

    // one bus access and the row a read should return
    typedef struct {
        cim_kind_e kind;
        cim_addr_t addr;
        cim_row_t  word;
        cim_row_t  exp_row;
    } step_t;

    logic      sys_clk_in;
    logic      sys_reset_in;
    avmm_req_t avmm_req;
    avmm_rsp_t avmm_rsp;

    step_t    steps[$];
    // expected array contents
    cim_row_t model_mem [`CIM_ROWS];
    integer   seed = 32'he127_d9f9;
    int       watchdog_cycles = 0;

    cim_top i_cim_top (
        .sys_clk_in   (sys_clk_in),
        .sys_reset_in (sys_reset_in),
        .avmm_req     (avmm_req),
        .avmm_rsp     (avmm_rsp)
    );

    initial
    begin
        sys_clk_in = 1'b0;
        forever
        begin
            #(CLK_PERIOD / 2) sys_clk_in = ~sys_clk_in;
        end
    end

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_row(input string name, input cim_row_t got, input cim_row_t exp);
        if (got !== exp)
        begin
            stop_on_error($sformatf("error at %0t: %s got %h expected %h",
                                    $time, name, got, exp));
        end
    endtask

    // waitrequest and readdatavalid only
    task automatic check_rsp(input avmm_rsp_t got, input avmm_rsp_t exp);
        if (got.waitrequest !== exp.waitrequest)
        begin
            stop_on_error($sformatf("error at %0t: avmm_rsp.waitrequest got %b expected %b",
                                    $time, got.waitrequest, exp.waitrequest));
        end
        if (got.readdatavalid !== exp.readdatavalid)
        begin
            stop_on_error($sformatf("error at %0t: avmm_rsp.readdatavalid got %b expected %b",
                                    $time, got.readdatavalid, exp.readdatavalid));
        end
    endtask

    function automatic avmm_rsp_t expected_rsp(input logic wait_bit, input logic valid_bit);
        avmm_rsp_t r;
        r               = '0;
        r.waitrequest   = wait_bit;
        r.readdatavalid = valid_bit;
        return r;
    endfunction

    task automatic load_row(input cim_addr_t addr, input cim_row_t word);
        step_t s;
        s.kind         = REQ_LOAD;
        s.addr         = addr;
        s.word         = word;
        s.exp_row      = word;
        model_mem[addr] = word;
        steps.push_back(s);
    endtask

    task automatic read_back(input cim_addr_t addr);
        step_t s;
        s.kind    = REQ_READ;
        s.addr    = addr;
        s.word    = '0;
        s.exp_row = model_mem[addr];
        steps.push_back(s);
    endtask

    // command word and the model update for it
    task automatic run_op(input logic [7:0] op, input cim_addr_t src_a,
                          input cim_addr_t src_b, input logic [7:0] low);
        step_t    s;
        cim_row_t a;
        cim_row_t b;
        a = model_mem[src_a];
        b = model_mem[src_b];
        case (op)
            // unary ops write into the src_b field row
            OP_MOVE:  model_mem[src_b] = a;
            OP_LSHFT: model_mem[src_b] = a << low[4:0];
            OP_RSHFT: model_mem[src_b] = a >> low[4:0];
            // binary ops write into the low byte row
            OP_ORC:   model_mem[low] = a | b;
            OP_ANDC:  model_mem[low] = a & b;
            OP_XORC:  model_mem[low] = a ^ b;
            // unknown opcodes leave the model alone
            default:  ;
        endcase
        s.kind    = REQ_EXEC;
        s.addr    = '0;
        s.word    = {op, src_a, src_b, low};
        s.exp_row = '0;
        steps.push_back(s);
    endtask

    task automatic build_table();
        logic [7:0] shift_low [3] = '{8'h00, 8'h1F, 8'hE7};
        logic [7:0] rand_ops [6] = '{OP_MOVE, OP_ORC, OP_ANDC, OP_XORC, OP_LSHFT, OP_RSHFT};
        int         i;
        int         sel;
        cim_addr_t  a;
        cim_addr_t  b;
        cim_addr_t  d;
        logic [7:0] low;
        logic       unary;
        for (i = 0; i < POOL_ROWS; i++)
        begin
            load_row(cim_addr_t'(i), $random(seed));
        end
        // shift sources with both end bits set
        load_row(8'd8, 32'hC000_0003);
        load_row(8'd9, 32'hC000_0003);
        read_back(8'd0);
        read_back(8'd7);
        load_row(8'hFF, 32'hA5A5_0F0F);
        read_back(8'hFF);
        load_row(8'h80, 32'h8000_0001);
        read_back(8'h80);
        // bitwise ops then their sources read back
        run_op(OP_ORC, 8'd1, 8'd2, 8'd10);
        read_back(8'd10);
        read_back(8'd1);
        read_back(8'd2);
        run_op(OP_ANDC, 8'd3, 8'd4, 8'd11);
        read_back(8'd11);
        read_back(8'd3);
        read_back(8'd4);
        run_op(OP_XORC, 8'd5, 8'd6, 8'd12);
        read_back(8'd12);
        read_back(8'd5);
        read_back(8'd6);
        run_op(OP_MOVE, 8'd7, 8'd13, 8'h00);
        read_back(8'd13);
        read_back(8'd7);
        // shamt 0, 31 and 7 with junk above bit 4
        for (i = 0; i < 3; i++)
        begin
            run_op(OP_LSHFT, 8'd8, 8'd14, shift_low[i]);
            read_back(8'd14);
            run_op(OP_RSHFT, 8'd9, 8'd15, shift_low[i]);
            read_back(8'd15);
        end
        // unknown opcodes touch nothing
        run_op(8'h02, 8'd1, 8'd2, 8'd3);
        run_op(8'hFF, 8'd4, 8'd5, 8'd6);
        for (i = 0; i < POOL_ROWS; i++)
        begin
            read_back(cim_addr_t'(i));
        end
        run_op(OP_XORC, 8'd0, 8'd1, 8'd2);
        read_back(8'd2);
        // random mix inside the pool
        for (i = 0; i < RANDOM_STEPS; i++)
        begin
            sel = $unsigned($random(seed)) % 7;
            a   = cim_addr_t'($unsigned($random(seed)) % POOL_ROWS);
            b   = cim_addr_t'($unsigned($random(seed)) % POOL_ROWS);
            d   = cim_addr_t'($unsigned($random(seed)) % POOL_ROWS);
            if (sel == 6)
            begin
                load_row(a, $random(seed));
                read_back(a);
            end
            else
            begin
                unary = (rand_ops[sel] == OP_MOVE) || (rand_ops[sel] == OP_LSHFT) ||
                        (rand_ops[sel] == OP_RSHFT);
                // unary ops take any low byte as its low bits hold the shamt
                low = unary ? 8'($random(seed)) : d;
                run_op(rand_ops[sel], a, b, low);
                read_back(unary ? b : d);
            end
        end
        for (i = 0; i < POOL_ROWS; i++)
        begin
            read_back(cim_addr_t'(i));
        end
    endtask

    // one access with cycle 0 as the accept cycle
    task automatic apply_step(input step_t s);
        avmm_req_t req_v;
        int        free_cycle;
        int        waited;
        int        c;
        logic      is_read;
        is_read          = (s.kind == REQ_READ);
        req_v.read       = is_read;
        req_v.write      = !is_read;
        req_v.address    = {(s.kind == REQ_LOAD), s.addr};
        req_v.writedata  = s.word;
        // waitrequest low again in cycle 3 for a load and in cycle 5 otherwise
        free_cycle = (s.kind == REQ_LOAD) ? 3 : 5;
        waited     = 0;
        @(negedge sys_clk_in);
        while (avmm_rsp.waitrequest !== 1'b0)
        begin
            waited++;
            if (waited > CYCLES_PER_STEP)
            begin
                stop_on_error("waitrequest stayed high before a new access");
            end
            @(negedge sys_clk_in);
        end
        @(posedge sys_clk_in);
        avmm_req <= req_v;
        @(negedge sys_clk_in);
        check_rsp(avmm_rsp, expected_rsp(1'b0, 1'b0));
        @(posedge sys_clk_in);
        avmm_req <= '0;
        for (c = 1; c <= free_cycle; c++)
        begin
            @(negedge sys_clk_in);
            // single readdatavalid pulse in cycle 4
            check_rsp(avmm_rsp, expected_rsp(c < free_cycle, is_read && (c == 4)));
            if (is_read && (c == 4))
            begin
                check_row($sformatf("avmm_rsp.readdata row %0d", s.addr),
                          avmm_rsp.readdata, s.exp_row);
            end
        end
    endtask

    initial
    begin
        sys_reset_in = 1'b1;
        avmm_req     = '0;
        build_table();
        watchdog_cycles = RESET_CYCLES + CYCLES_PER_STEP * steps.size() + WATCHDOG_MARGIN;
        repeat (RESET_CYCLES)
        begin
            @(negedge sys_clk_in);
            check_rsp(avmm_rsp, expected_rsp(1'b1, 1'b0));
        end
        @(posedge sys_clk_in);
        sys_reset_in <= 1'b0;
        // idle straight out of reset
        repeat (3)
        begin
            @(negedge sys_clk_in);
            check_rsp(avmm_rsp, expected_rsp(1'b0, 1'b0));
        end
        foreach (steps[i])
        begin
            apply_step(steps[i]);
        end
        @(negedge sys_clk_in);
        check_rsp(avmm_rsp, expected_rsp(1'b0, 1'b0));
        $display("=== PASS ===");
        $finish;
    end

    // sized once the table is built
    initial
    begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles)
        begin
            @(posedge sys_clk_in);
        end
        stop_on_error("timeout: the access table did not finish in time");
    end

endmodule

/* hw/cim_top.sv */
/*
 * compute-in-memory row controller
 * Avalon-MM slave around a row array with a bitwise row ALU
 */
`timescale 1ns/100ps

module cim_top
    import cim_pkg::*;
(
    input  logic      sys_clk_in,
    input  logic      sys_reset_in,
    input  avmm_req_t avmm_req,
    output avmm_rsp_t avmm_rsp
);

    logic         waitrequest;
    logic         req_strobe;
    cim_req_t     req;
    logic         done_strobe;
    logic         read_strobe;
    cim_rd_t      rd;
    cim_wr_t      wr;
    cim_alu_ctl_t alu_ctl;
    cim_row_t     alu_result;
    cim_row_t     row_a;
    cim_row_t     row_b;
    cim_row_t     readdata;
    logic         readdatavalid;

    // bus side
    cim_bus_decode i_cim_bus_decode (
        .sys_clk_in   (sys_clk_in),
        .sys_reset_in (sys_reset_in),
        .avmm_req     (avmm_req),
        .done_strobe  (done_strobe),
        .waitrequest  (waitrequest),
        .req_strobe   (req_strobe),
        .req          (req)
    );

    cim_sequencer i_cim_sequencer (
        .sys_clk_in   (sys_clk_in),
        .sys_reset_in (sys_reset_in),
        .req_strobe   (req_strobe),
        .req          (req),
        .rd           (rd),
        .wr_ctl       (wr),
        .alu_ctl      (alu_ctl),
        .alu_result   (alu_result),
        .read_strobe  (read_strobe),
        .done_strobe  (done_strobe)
    );

    cim_row_array i_cim_row_array (
        .sys_clk_in (sys_clk_in),
        .rd         (rd),
        .wr         (wr),
        .row_a      (row_a),
        .row_b      (row_b)
    );

    cim_row_alu i_cim_row_alu (
        .row_a   (row_a),
        .row_b   (row_b),
        .alu_ctl (alu_ctl),
        .result  (alu_result)
    );

    // read data path back to the host
    cim_read_return i_cim_read_return (
        .sys_clk_in    (sys_clk_in),
        .sys_reset_in  (sys_reset_in),
        .read_strobe   (read_strobe),
        .row_a         (row_a),
        .readdata      (readdata),
        .readdatavalid (readdatavalid)
    );

    assign avmm_rsp.waitrequest   = waitrequest;
    assign avmm_rsp.readdatavalid = readdatavalid;
    assign avmm_rsp.readdata      = readdata;

endmodule

/* hw/cim_read_return.sv */
/*
 * read return
 * captures the read row and drives the readdatavalid pulse
 */
`timescale 1ns/100ps

module cim_read_return
    import cim_pkg::*;
(
    input  logic     sys_clk_in,
    input  logic     sys_reset_in,
    input  logic     read_strobe,
    input  cim_row_t row_a,
    output cim_row_t readdata,
    output logic     readdatavalid
);

    // one pulse per read, the cycle after the strobe
    always_ff @(posedge sys_clk_in or posedge sys_reset_in)
    begin
        if (sys_reset_in)
        begin
            readdatavalid <= 1'b0;
        end
        else
        begin
            readdatavalid <= read_strobe;
        end
    end

    // holds the last row read
    always_ff @(posedge sys_clk_in)
    begin
        if (read_strobe)
        begin
            readdata <= row_a;
        end
    end

endmodule

/* hw/cim_row_array.sv */
/*
 * row array
 * CIM_ROWS rows, two registered read ports and one write port
 */
`timescale 1ns/100ps
`include "cim_settings.svh"

module cim_row_array
    import cim_pkg::*;
(
    input  logic     sys_clk_in,
    input  cim_rd_t  rd,
    input  cim_wr_t  wr,
    output cim_row_t row_a,
    output cim_row_t row_b
);

    // contents undefined until loaded
    cim_row_t mem [`CIM_ROWS];

    always_ff @(posedge sys_clk_in)
    begin
        if (wr.en)
        begin
            mem[wr.addr] <= wr.data;
        end
    end

    // one cycle read latency, old data on a same-row write
    always_ff @(posedge sys_clk_in)
    begin
        row_a <= mem[rd.addr_a];
        row_b <= mem[rd.addr_b];
    end

endmodule

/* hw/cim_row_alu.sv */
/*
 * row ALU
 * bitwise combine of two rows, or a logical shift of the first
 */
`timescale 1ns/100ps

module cim_row_alu
    import cim_pkg::*;
(
    input  cim_row_t     row_a,
    input  cim_row_t     row_b,
    input  cim_alu_ctl_t alu_ctl,
    output cim_row_t     result
);

    always_comb
    begin
        case (alu_ctl.op)
            // copy for MOVE
            ALU_PASS:
            begin
                result = row_a;
            end
            ALU_OR:
            begin
                result = row_a | row_b;
            end
            ALU_AND:
            begin
                result = row_a & row_b;
            end
            ALU_XOR:
            begin
                result = row_a ^ row_b;
            end
            // zero fill both ways
            ALU_SHL:
            begin
                result = row_a << alu_ctl.shamt;
            end
            ALU_SHR:
            begin
                result = row_a >> alu_ctl.shamt;
            end
            default:
            begin
                result = row_a;
            end
        endcase
    end

endmodule

/* hw/cim_sequencer.sv */
/*
 * command sequencer
 * steps each request through fetch and compute or retire,
 * drives the array ports, the ALU function and the completion strobes
 */
`timescale 1ns/100ps

module cim_sequencer
    import cim_pkg::*;
(
    input  logic         sys_clk_in,
    input  logic         sys_reset_in,
    input  logic         req_strobe,
    input  cim_req_t     req,
    output cim_rd_t      rd,
    output cim_wr_t      wr_ctl,
    output cim_alu_ctl_t alu_ctl,
    input  cim_row_t     alu_result,
    output logic         read_strobe,
    output logic         done_strobe
);

    typedef enum logic [1:0] {
        IDLE,
        FETCH,
        COMPUTE,
        RETIRE
    } seq_state_e;

    seq_state_e state;
    seq_state_e next_state;
    cim_cmd_t   req_cmd;
    cim_cmd_t   cmd_q;
    cim_rd_t    rd_issue;
    cim_rd_t    rd_q;
    logic       is_read_q;
    logic       start;
    logic       load_go;
    logic       op_known;
    logic       op_unary;

    assign req_cmd = cim_cmd_t'(req.word);
    assign start   = (state == IDLE) && req_strobe;
    // a load writes straight through in the strobe cycle
    assign load_go = start && (req.kind == REQ_LOAD);

    // read rows for the incoming request
    always_comb
    begin
        rd_issue.addr_a = (req.kind == REQ_READ) ? req.addr : req_cmd.src_a;
        rd_issue.addr_b = req_cmd.src_b;
    end

    // array registers the issue address at the end of the strobe cycle,
    // then keeps rereading the held address so rows stay put
    assign rd = (state == IDLE) ? rd_issue : rd_q;

    // opcode to ALU function
    always_comb
    begin
        alu_ctl.op    = ALU_PASS;
        alu_ctl.shamt = cmd_q.low.shift.shamt;
        op_known      = 1'b1;
        op_unary      = 1'b0;
        case (cmd_q.opcode)
            OP_MOVE:
            begin
                op_unary = 1'b1;
            end
            OP_ORC:   alu_ctl.op = ALU_OR;
            OP_ANDC:  alu_ctl.op = ALU_AND;
            OP_XORC:  alu_ctl.op = ALU_XOR;
            OP_LSHFT:
            begin
                alu_ctl.op = ALU_SHL;
                op_unary   = 1'b1;
            end
            OP_RSHFT:
            begin
                alu_ctl.op = ALU_SHR;
                op_unary   = 1'b1;
            end
            // anything else completes as a no-op
            default:  op_known = 1'b0;
        endcase
    end

    always_comb
    begin
        next_state = state;
        case (state)
            IDLE:
            begin
                if (start && (req.kind != REQ_LOAD))
                begin
                    next_state = FETCH;
                end
            end
            // rows valid from the array here
            FETCH:
            begin
                if (is_read_q || !op_known)
                begin
                    next_state = RETIRE;
                end
                else
                begin
                    next_state = COMPUTE;
                end
            end
            COMPUTE: next_state = IDLE;
            RETIRE:  next_state = IDLE;
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge sys_clk_in or posedge sys_reset_in)
    begin
        if (sys_reset_in)
        begin
            state     <= IDLE;
            is_read_q <= 1'b0;
        end
        else
        begin
            state <= next_state;
            if (start)
            begin
                is_read_q <= (req.kind == REQ_READ);
            end
        end
    end

    // latched command and read addresses
    always_ff @(posedge sys_clk_in)
    begin
        if (start)
        begin
            cmd_q <= req_cmd;
            rd_q  <= rd_issue;
        end
    end

    // write port, load word or ALU result
    always_comb
    begin
        wr_ctl.en   = 1'b0;
        wr_ctl.addr = req.addr;
        wr_ctl.data = req.word;
        if (load_go)
        begin
            wr_ctl.en = 1'b1;
        end
        else if (state == COMPUTE)
        begin
            wr_ctl.en   = 1'b1;
            // unary ops land in [15:8], binary ops in [7:0]
            wr_ctl.addr = op_unary ? cmd_q.src_b : cmd_q.low.dst;
            wr_ctl.data = alu_result;
        end
    end

    assign read_strobe = (state == RETIRE) && is_read_q;
    assign done_strobe = load_go || (state == COMPUTE) || (state == RETIRE);

endmodule

/* hw/cim_bus_decode.sv */
/*
 * Avalon-MM request decoder
 * accepts one request at a time, sorts it into load, exec or read
 * and holds waitrequest until the sequencer has finished it
 */
`timescale 1ns/100ps
`include "cim_settings.svh"

module cim_bus_decode
    import cim_pkg::*;
(
    input  logic      sys_clk_in,
    input  logic      sys_reset_in,
    input  avmm_req_t avmm_req,
    input  logic      done_strobe,
    output logic      waitrequest,
    output logic      req_strobe,
    output cim_req_t  req
);

    logic accept;
    logic busy;
    logic done_q;

    // Avalon accept rule
    assign accept = (avmm_req.read | avmm_req.write) & ~waitrequest;

    // held off during reset, otherwise follows busy
    assign waitrequest = busy | sys_reset_in;

    always_ff @(posedge sys_clk_in or posedge sys_reset_in)
    begin
        if (sys_reset_in)
        begin
            busy       <= 1'b0;
            done_q     <= 1'b0;
            req_strobe <= 1'b0;
        end
        else
        begin
            req_strobe <= accept;
            // release one cycle after the sequencer finishes
            done_q     <= done_strobe;
            if (accept)
            begin
                busy <= 1'b1;
            end
            else if (done_q)
            begin
                busy <= 1'b0;
            end
        end
    end

    // request payload, only meaningful alongside req_strobe
    always_ff @(posedge sys_clk_in)
    begin
        if (accept)
        begin
            // write wins if the host drives both
            if (avmm_req.write)
            begin
                // top address bit marks a row load
                if (avmm_req.address[`CIM_BUS_ADDR_WIDTH-1])
                begin
                    req.kind <= REQ_LOAD;
                end
                else
                begin
                    req.kind <= REQ_EXEC;
                end
            end
            else
            begin
                req.kind <= REQ_READ;
            end
            req.addr <= avmm_req.address[`CIM_ADDR_WIDTH-1:0];
            req.word <= avmm_req.writedata;
        end
    end

endmodule

/* hw/cim_pkg.sv */
/*
 * compute-in-memory row controller types
 * command layout, internal request and control records, Avalon bundles
 */
`include "cim_settings.svh"

package cim_pkg;

    typedef logic [`CIM_ROW_WIDTH-1:0] cim_row_t;
    typedef logic [`CIM_ADDR_WIDTH-1:0] cim_addr_t;

    // opcode encodings of the row instruction set
    typedef enum logic [`CIM_OP_WIDTH-1:0] {
        OP_MOVE  = 8'h01,
        OP_ORC   = 8'h03,
        OP_ANDC  = 8'h04,
        OP_XORC  = 8'h05,
        OP_LSHFT = 8'h08,
        OP_RSHFT = 8'h09
    } cim_op_e;

    // low byte is dst for binary ops and shamt for shifts
    typedef union packed {
        cim_addr_t dst;
        struct packed {
            logic [`CIM_ADDR_WIDTH-`CIM_SHAMT_WIDTH-1:0] rsvd;
            logic [`CIM_SHAMT_WIDTH-1:0]                 shamt;
        } shift;
    } cim_cmd_low_u;

    typedef struct packed {
        cim_op_e      opcode;
        cim_addr_t    src_a;
        cim_addr_t    src_b;
        cim_cmd_low_u low;
    } cim_cmd_t;

    typedef enum logic [1:0] {
        REQ_LOAD = 2'd0,
        REQ_EXEC = 2'd1,
        REQ_READ = 2'd2
    } cim_kind_e;

    typedef struct packed {
        cim_kind_e kind;
        cim_addr_t addr;
        cim_row_t  word;
    } cim_req_t;

    typedef enum logic [2:0] {
        ALU_PASS,
        ALU_OR,
        ALU_AND,
        ALU_XOR,
        ALU_SHL,
        ALU_SHR
    } cim_alu_op_e;

    typedef struct packed {
        cim_alu_op_e                 op;
        logic [`CIM_SHAMT_WIDTH-1:0] shamt;
    } cim_alu_ctl_t;

    typedef struct packed {
        cim_addr_t addr_a;
        cim_addr_t addr_b;
    } cim_rd_t;

    typedef struct packed {
        logic      en;
        cim_addr_t addr;
        cim_row_t  data;
    } cim_wr_t;

    typedef struct packed {
        logic                           read;
        logic                           write;
        logic [`CIM_BUS_ADDR_WIDTH-1:0] address;
        cim_row_t                       writedata;
    } avmm_req_t;

    typedef struct packed {
        logic     waitrequest;
        logic     readdatavalid;
        cim_row_t readdata;
    } avmm_rsp_t;

endpackage

/* include/cim_settings.svh */
/*
 * compute-in-memory row controller settings
 * widths and depths shared by the package and the RTL blocks
 */
`ifndef CIM_SETTINGS_SVH
`define CIM_SETTINGS_SVH

// one row, also the Avalon data width
`define CIM_ROW_WIDTH 32

// row address into the array
`define CIM_ADDR_WIDTH 8

// number of rows held in the array
`define CIM_ROWS 256

// Avalon word address, top bit selects row load
`define CIM_BUS_ADDR_WIDTH 9

// command word fields
`define CIM_OP_WIDTH 8
`define CIM_SHAMT_WIDTH 5

`endif
